/* filelist.f */
+incdir+design
+incdir+verif
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
verif/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module rv_core_tb -f filelist.f -o rv_core_sim &&
	./obj_dir/rv_core_sim | tee /dev/stderr | grep -qx "sim passed" &&
	echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }

/* verif/rv_ref_model.svh */
/*
 * Reference model for the RV32I core testbench
 *   LCG random source and instruction encoders
 *   random program generator with forward-only control flow
 *   instruction-set model producing expected retires and stores
 */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic int unsigned rand_below(input int unsigned n);
	return (lcg_next() >> 8) % n;
endfunction

function automatic logic rand_bit();
	logic [31:0] v;

	v = lcg_next();
	return v[20];
endfunction

// Small register set so that dependent pairs are common
function automatic logic [4:0] rand_reg();
	return 5'(rand_below(8));
endfunction

function automatic logic [31:0] fill_word(input logic [31:0] addr);
	return (addr * 32'h9e37_79b1) ^ 32'h3c6e_f372;
endfunction

function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, `OPC_OP};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2);
	return {imm[11:5], rs2, 5'd0, `F3_W, imm[4:0], `OPC_STORE};
endfunction

function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
endfunction

function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
endfunction

// ========================================================================
// Program generator
// ========================================================================
task automatic build_program();
	int unsigned	kind;
	int unsigned	t;
	logic [2:0]		f3;
	logic [4:0]		shamt;
	logic [11:0]	imm;

	// Words past the program hold unknown opcodes
	for (int i = 0; i < 128; i++) begin
		imem[i] = 32'(i) << 7;
	end
	// Prologue gives x1..x7 defined values
	for (int r = 1; r < 8; r++) begin
		imem[r - 1] = i_word(12'(rand_below(4096)), 5'd0, `F3_ADD, 5'(r), `OPC_OP_IMM);
	end
	for (int p = 7; p < 95; p++) begin
		kind	= rand_below(10);
		f3		= 3'(rand_below(8));
		shamt	= 5'(rand_below(32));
		t		= p + 1 + rand_below((95 - p) < 4 ? (95 - p) : 4);
		case (kind)
			0, 1, 2: begin
				imem[p] = r_word((f3 == `F3_ADD || f3 == `F3_SR) ?
					{1'b0, rand_bit(), 5'd0} : 7'd0, rand_reg(), rand_reg(), f3, rand_reg());
			end
			3, 4: begin
				if (f3 == `F3_SLL)
					imm = {7'd0, shamt};
				else if (f3 == `F3_SR)
					imm = {1'b0, rand_bit(), 5'd0, shamt};
				else
					imm = 12'(rand_below(4096));
				imem[p] = i_word(imm, rand_reg(), f3, rand_reg(), `OPC_OP_IMM);
			end
			5: begin
				imem[p] = {20'(lcg_next() >> 12), rand_reg(),
					rand_bit() ? `OPC_LUI : `OPC_AUIPC};
			end
			6: imem[p] = i_word(12'(4 * rand_below(64)), 5'd0, `F3_W, rand_reg(), `OPC_LOAD);
			7: imem[p] = s_word(12'(4 * rand_below(64)), rand_reg());
			8: begin
				kind	= rand_below(6);
				f3		= 3'(kind < 2 ? kind : kind + 2);
				imem[p] = b_word(13'((t - p) * 4), rand_reg(), rand_reg(), f3);
			end
			default: begin
				if (rand_bit())
					imem[p] = j_word(21'((t - p) * 4), rand_reg());
				else
					imem[p] = i_word(12'(t * 4), 5'd0, 3'd0, rand_reg(), `OPC_JALR);
			end
		endcase
	end
	imem[95] = j_word(21'd0, 5'd0);
endtask

// ========================================================================
// Instruction-set model
// ========================================================================
function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	logic [31:0] res;

	case (f3)
		`F3_ADD:	res = alt ? a - b : a + b;
		`F3_SLL:	res = a << b[4:0];
		`F3_SLT:	res = {31'd0, $signed(a) < $signed(b)};
		`F3_SLTU:	res = {31'd0, a < b};
		`F3_XOR:	res = a ^ b;
		`F3_OR:		res = a | b;
		`F3_AND:	res = a & b;
		default: begin
			if (alt)
				res = $signed(a) >>> b[4:0];
			else
				res = a >> b[4:0];
		end
	endcase
	return res;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	case (f3)
		`F3_BEQ:	return a == b;
		`F3_BNE:	return a != b;
		`F3_BLT:	return $signed(a) < $signed(b);
		`F3_BGE:	return $signed(a) >= $signed(b);
		`F3_BLTU:	return a < b;
		`F3_BGEU:	return a >= b;
		default:	return 1'b0;
	endcase
endfunction

task automatic model_step(input logic [31:0] pc, output logic [31:0] next_pc,
	output rv_pkg::retire_t ret, output logic is_store, output rv_pkg::dmem_req_t st);
	logic [31:0]	w;
	logic [31:0]	a;
	logic [31:0]	b;
	logic [31:0]	imm_i;
	logic [31:0]	addr;
	logic [31:0]	res;
	logic			wr;

	w			= imem[pc[8:2]];
	a			= regs_m[w[19:15]];
	b			= regs_m[w[24:20]];
	imm_i		= {{20{w[31]}}, w[31:20]};
	next_pc		= pc + 32'd4;
	res			= 32'd0;
	wr			= 1'b1;
	is_store	= 1'b0;
	st			= '0;
	case (w[6:0])
		`OPC_OP:		res = alu_model(w[14:12], w[30], a, b);
		`OPC_OP_IMM:	res = alu_model(w[14:12], w[14:12] == `F3_SR && w[30], a, imm_i);
		`OPC_LUI:		res = {w[31:12], 12'd0};
		`OPC_AUIPC:		res = pc + {w[31:12], 12'd0};
		`OPC_LOAD: begin
			addr	= a + imm_i;
			res		= mem_m[addr[7:2]];
		end
		`OPC_STORE: begin
			addr		= a + {{20{w[31]}}, w[31:25], w[11:7]};
			wr			= 1'b0;
			is_store	= 1'b1;
			st.we		= 1'b1;
			st.addr		= addr;
			st.wdata	= b;
			mem_m[addr[7:2]] = b;
		end
		`OPC_BRANCH: begin
			wr = 1'b0;
			if (branch_taken(w[14:12], a, b))
				next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		end
		`OPC_JAL: begin
			res		= pc + 32'd4;
			next_pc	= pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		end
		`OPC_JALR: begin
			res		= pc + 32'd4;
			next_pc	= (a + imm_i) & ~32'd1;
		end
		default:	wr = 1'b0;
	endcase
	ret.valid	= 1'b1;
	ret.pc		= pc;
	ret.rd		= w[11:7];
	ret.we		= wr && w[11:7] != 5'd0;
	ret.value	= ret.we ? res : 32'd0;
	if (ret.we)
		regs_m[w[11:7]] = res;
endtask

// Runs to the self-loop, which retires once in the expected stream
task automatic run_model();
	logic [31:0]		pc;
	logic [31:0]		next_pc;
	rv_pkg::retire_t	ret;
	rv_pkg::dmem_req_t	st;
	logic				is_store;
	int					steps;

	for (int i = 0; i < 32; i++) begin
		regs_m[i] = 32'd0;
	end
	pc		= `RESET_PC;
	next_pc	= `RESET_PC;
	steps	= 0;
	do begin
		pc = next_pc;
		model_step(pc, next_pc, ret, is_store, st);
		exp_ret.push_back(ret);
		if (is_store)
			exp_st.push_back(st);
		steps++;
	end while (next_pc != pc && steps < 1000);
	if (next_pc != pc)
		report_failure("reference model never reached the final self-loop");
endtask

`endif

/* verif/rv_core_tb.sv */
/*
 * Testbench for the RV32I core
 *   clock, reset and behavioral instruction and data memories
 *   compare tasks for retire reports and store requests
 *   checks the retire stream against the reference model
 */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_tb;
	logic					i_clk;
	logic					i_rstn;
	logic [`XLEN-1:0]		i_imem_data;
	logic [`XLEN-1:0]		i_dmem_rdata;
	logic [`XLEN-1:0]		imem_addr;
	rv_pkg::dmem_req_t		dmem_req;
	rv_pkg::retire_t		retire;

	// Memories seen by the DUT
	logic [`XLEN-1:0]		imem [0:127];
	logic [`XLEN-1:0]		dmem [0:63];
	logic					rd_pend;
	logic [5:0]				rd_pend_idx;

	// Reference model state and expected streams
	logic [`XLEN-1:0]		regs_m [0:31];
	logic [`XLEN-1:0]		mem_m [0:63];
	logic [31:0]			lcg_state;
	rv_pkg::retire_t		exp_ret [$];
	rv_pkg::dmem_req_t		exp_st [$];
	rv_pkg::dmem_req_t		st_next;
	int						n_done;

	rv_core dut_i (
		.i_clk			(i_clk			),
		.i_rstn			(i_rstn			),
		.o_imem_addr	(imem_addr		),
		.i_imem_data	(i_imem_data	),
		.o_dmem			(dmem_req		),
		.i_dmem_rdata	(i_dmem_rdata	),
		.o_retire		(retire			)
	);

	always #20 i_clk = ~i_clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	`include "rv_ref_model.svh"

	task automatic check_retire(input rv_pkg::retire_t exp);
		if (retire.pc !== exp.pc)
			report_mismatch("o_retire.pc", retire.pc, exp.pc);
		if (retire.we !== exp.we)
			report_mismatch("o_retire.we", 32'(retire.we), 32'(exp.we));
		if (retire.rd !== exp.rd)
			report_mismatch("o_retire.rd", 32'(retire.rd), 32'(exp.rd));
		if (retire.value !== exp.value)
			report_mismatch("o_retire.value", retire.value, exp.value);
	endtask

	task automatic check_store(input rv_pkg::dmem_req_t exp);
		if (dmem_req.re !== exp.re)
			report_mismatch("o_dmem.re", 32'(dmem_req.re), 32'(exp.re));
		if (dmem_req.addr !== exp.addr)
			report_mismatch("o_dmem.addr", dmem_req.addr, exp.addr);
		if (dmem_req.wdata !== exp.wdata)
			report_mismatch("o_dmem.wdata", dmem_req.wdata, exp.wdata);
	endtask

	task automatic wait_retire(input logic first);
		int cycles;

		cycles = 0;
		do begin
			@(posedge i_clk);
			cycles++;
			if (first && dmem_req.we !== 1'b0)
				report_failure("data memory write seen before the first retire");
			if (cycles >= 2000)
				report_failure("timeout after 2000 cycles waiting for a retire");
		end while (retire.valid !== 1'b1);
	endtask

	// ========================================================================
	// Memories
	// ========================================================================
	// Load data of the previous cycle's request shows up mid-cycle
	always @(negedge i_clk) begin
		i_imem_data		= imem[imem_addr[8:2]];
		i_dmem_rdata	= rd_pend ? dmem[rd_pend_idx] : '0;
	end

	always @(posedge i_clk) begin
		if (dmem_req.we === 1'b1) begin
			if (exp_st.size() == 0) begin
				report_failure("store seen after the last store of the program");
			end else begin
				st_next = exp_st.pop_front();
				check_store(st_next);
				dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
			end
		end
		rd_pend		= dmem_req.re === 1'b1;
		rd_pend_idx	= dmem_req.addr[7:2];
	end

	// ========================================================================
	// Stimulus and checking
	// ========================================================================
	initial begin
		i_clk			= 1'b0;
		i_rstn			= 1'b0;
		i_imem_data		= '0;
		i_dmem_rdata	= '0;
		rd_pend			= 1'b0;
		rd_pend_idx		= '0;
		n_done			= 0;
		lcg_state		= 32'h79b5;
		build_program();
		for (int i = 0; i < 64; i++) begin
			dmem[i]		= fill_word(32'(i) << 2);
			mem_m[i]	= dmem[i];
		end
		run_model();

		// State is undefined until the first edge with reset low
		for (int c = 0; c < 16; c++) begin
			@(posedge i_clk);
			if (c > 0 && retire.valid !== 1'b0)
				report_failure("o_retire.valid is not low during reset");
			if (c > 0 && dmem_req.we !== 1'b0)
				report_failure("o_dmem.we is not low during reset");
		end
		@(negedge i_clk);
		i_rstn = 1'b1;

		while (n_done < exp_ret.size()) begin
			wait_retire(n_done == 0);
			check_retire(exp_ret[n_done]);
			n_done++;
		end

		if (exp_st.size() != 0) begin
			report_failure("stores of the program never appeared at the data port");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* design/rv_core.sv */
/*
 * RV32I core top level
 *   decode, execute and result stages
 *   redirect and writeback wiring between stages
 */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core (
	input  logic				i_clk,
	input  logic				i_rstn,
	output logic [`XLEN-1:0]	o_imem_addr,
	input  logic [`XLEN-1:0]	i_imem_data,
	output rv_pkg::dmem_req_t	o_dmem,
	input  logic [`XLEN-1:0]	i_dmem_rdata,
	output rv_pkg::retire_t		o_retire
);
	rv_pkg::de_stage_t	de;
	rv_pkg::ew_stage_t	ew;
	rv_pkg::wb_fwd_t	wb;
	logic				redirect_valid;
	logic [`XLEN-1:0]	redirect_pc;

	rv_decode u_decode (
		.i_clk				(i_clk				),
		.i_rstn				(i_rstn				),
		.o_imem_addr		(o_imem_addr		),
		.i_imem_data		(i_imem_data		),
		.i_redirect_valid	(redirect_valid		),
		.i_redirect_pc		(redirect_pc		),
		.i_wb				(wb					),
		.o_de				(de					)
	);

	rv_execute u_execute (
		.i_clk				(i_clk				),
		.i_rstn				(i_rstn				),
		.i_de				(de					),
		.i_wb				(wb					),
		.o_redirect_valid	(redirect_valid		),
		.o_redirect_pc		(redirect_pc		),
		.o_dmem				(o_dmem				),
		.o_ew				(ew					)
	);

	rv_result u_result (
		.i_clk				(i_clk				),
		.i_rstn				(i_rstn				),
		.i_ew				(ew					),
		.i_dmem_rdata		(i_dmem_rdata		),
		.o_wb				(wb					),
		.o_retire			(o_retire			)
	);

endmodule

/* design/rv_result.sv */
/*
 * Result stage
 *   writeback select between load data and the execute value
 *   writeback bundle for register file and forwarding, retire report
 */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_result (
	input  logic				i_clk,
	input  logic				i_rstn,
	input  rv_pkg::ew_stage_t	i_ew,
	input  logic [`XLEN-1:0]	i_dmem_rdata,
	output rv_pkg::wb_fwd_t		o_wb,
	output rv_pkg::retire_t		o_retire
);
	logic				wb_we;
	logic [`XLEN-1:0]	wb_value;

	// Load data arrives one cycle after the request, i.e. now
	assign wb_value	= i_ew.is_load ? i_dmem_rdata : i_ew.value;
	assign wb_we	= i_ew.valid && i_ew.reg_we && i_ew.rd != 5'd0;

	assign o_wb.we		= wb_we;
	assign o_wb.rd		= i_ew.rd;
	assign o_wb.value	= wb_value;

	assign o_retire.valid	= i_ew.valid;
	assign o_retire.pc		= i_ew.pc;
	assign o_retire.rd		= i_ew.rd;
	assign o_retire.we		= wb_we;
	assign o_retire.value	= wb_we ? wb_value : '0;

	// Every load carries a register write for its data
	a_load_writes_reg: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_ew.is_load |-> (i_ew.valid && i_ew.reg_we));

endmodule

/* design/rv_execute.sv */
/*
 * Execute stage
 *   operand forwarding from the result stage and the ALU
 *   branch and jump resolution with PC redirect
 *   data memory request and execute/result register
 */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_execute (
	input  logic				i_clk,
	input  logic				i_rstn,
	input  rv_pkg::de_stage_t	i_de,
	input  rv_pkg::wb_fwd_t		i_wb,
	output logic				o_redirect_valid,
	output logic [`XLEN-1:0]	o_redirect_pc,
	output rv_pkg::dmem_req_t	o_dmem,
	output rv_pkg::ew_stage_t	o_ew
);
	logic [`XLEN-1:0]	rs1_val;
	logic [`XLEN-1:0]	rs2_val;
	logic [`XLEN-1:0]	op_a;
	logic [`XLEN-1:0]	op_b;
	logic [`XLEN-1:0]	alu_res;
	logic [`XLEN-1:0]	pc_plus4;
	logic [`XLEN-1:0]	jalr_sum;
	logic				taken;

	function automatic logic [`XLEN-1:0] fwd(input logic [4:0] idx,
		input logic [`XLEN-1:0] data, input rv_pkg::wb_fwd_t wb);
		fwd = (wb.we && wb.rd != 5'd0 && wb.rd == idx) ? wb.value : data;
	endfunction

	// ========================================================================
	// Operands and ALU
	// ========================================================================
	assign rs1_val	= fwd(i_de.rs1, i_de.rs1_data, i_wb);
	assign rs2_val	= fwd(i_de.rs2, i_de.rs2_data, i_wb);
	assign op_a		= i_de.ctrl.src_a_pc ? i_de.pc : rs1_val;
	assign op_b		= i_de.ctrl.src_b_imm ? i_de.imm : rs2_val;

	always_comb begin
		case (i_de.ctrl.alu_op)
			rv_pkg::ALU_SUB:	alu_res = op_a - op_b;
			rv_pkg::ALU_AND:	alu_res = op_a & op_b;
			rv_pkg::ALU_OR:		alu_res = op_a | op_b;
			rv_pkg::ALU_XOR:	alu_res = op_a ^ op_b;
			rv_pkg::ALU_SLL:	alu_res = op_a << op_b[4:0];
			rv_pkg::ALU_SRL:	alu_res = op_a >> op_b[4:0];
			rv_pkg::ALU_SRA:	alu_res = $signed(op_a) >>> op_b[4:0];
			rv_pkg::ALU_SLT:	alu_res = `XLEN'($signed(op_a) < $signed(op_b));
			rv_pkg::ALU_SLTU:	alu_res = `XLEN'(op_a < op_b);
			default:			alu_res = op_a + op_b;
		endcase
	end

	// ========================================================================
	// Branches and jumps
	// ========================================================================
	always_comb begin
		case (i_de.ctrl.funct3)
			`F3_BEQ:	taken = rs1_val == rs2_val;
			`F3_BNE:	taken = rs1_val != rs2_val;
			`F3_BLT:	taken = $signed(rs1_val) < $signed(rs2_val);
			`F3_BGE:	taken = $signed(rs1_val) >= $signed(rs2_val);
			`F3_BLTU:	taken = rs1_val < rs2_val;
			`F3_BGEU:	taken = rs1_val >= rs2_val;
			default:	taken = 1'b0;
		endcase
	end

	assign pc_plus4	= i_de.pc + 32'd4;
	assign jalr_sum	= rs1_val + i_de.imm;

	assign o_redirect_valid = i_de.valid && (i_de.ctrl.is_jal || i_de.ctrl.is_jalr ||
		(i_de.ctrl.is_branch && taken));
	assign o_redirect_pc = i_de.ctrl.is_jalr ? {jalr_sum[`XLEN-1:1], 1'b0} :
		i_de.pc + i_de.imm;

	// Data memory, address from the ALU
	assign o_dmem.re	= i_de.valid && i_de.ctrl.mem_re;
	assign o_dmem.we	= i_de.valid && i_de.ctrl.mem_we;
	assign o_dmem.addr	= alu_res;
	assign o_dmem.wdata	= rs2_val;

	// Execute/result register
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			o_ew.valid		<= 1'b0;
			o_ew.reg_we		<= 1'b0;
			o_ew.is_load	<= 1'b0;
		end else begin
			o_ew.valid		<= i_de.valid;
			o_ew.reg_we		<= i_de.valid && i_de.ctrl.reg_we;
			o_ew.is_load	<= i_de.valid && i_de.ctrl.mem_re;
		end
		o_ew.pc		<= i_de.pc;
		o_ew.rd		<= i_de.rd;
		o_ew.value	<= i_de.ctrl.wb_link ? pc_plus4 : alu_res;
	end

	// Decode never marks one instruction as both load and store
	a_dmem_rw_exclusive: assert property (@(posedge i_clk) disable iff (!i_rstn)
		!(o_dmem.we && o_dmem.re));

endmodule

/* design/rv_decode.sv */
/*
 * Front end and decode stage
 *   PC register and fetch/decode register
 *   field decode into execute controls, immediate generation
 *   register file and decode/execute register
 */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_decode (
	input  logic				i_clk,
	input  logic				i_rstn,
	output logic [`XLEN-1:0]	o_imem_addr,
	input  logic [`XLEN-1:0]	i_imem_data,
	input  logic				i_redirect_valid,
	input  logic [`XLEN-1:0]	i_redirect_pc,
	input  rv_pkg::wb_fwd_t		i_wb,
	output rv_pkg::de_stage_t	o_de
);
	logic [`XLEN-1:0]	pc;
	logic				fd_valid;
	logic [`XLEN-1:0]	fd_pc;
	rv_pkg::instr_u		fd_instr;
	rv_pkg::ex_ctrl_t	ctrl;
	logic [`XLEN-1:0]	imm;
	logic [4:0]			rs1;
	logic [`XLEN-1:0]	rs1_data;
	logic [`XLEN-1:0]	rs2_data;

	function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			`F3_ADD:	alu_sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			`F3_SLL:	alu_sel = rv_pkg::ALU_SLL;
			`F3_SLT:	alu_sel = rv_pkg::ALU_SLT;
			`F3_SLTU:	alu_sel = rv_pkg::ALU_SLTU;
			`F3_XOR:	alu_sel = rv_pkg::ALU_XOR;
			`F3_SR:		alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			`F3_OR:		alu_sel = rv_pkg::ALU_OR;
			default:	alu_sel = rv_pkg::ALU_AND;
		endcase
	endfunction

	// ========================================================================
	// Fetch
	// ========================================================================
	assign o_imem_addr = pc;

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			pc			<= `RESET_PC;
			fd_valid	<= 1'b0;
		end else begin
			pc			<= i_redirect_valid ? i_redirect_pc : pc + 32'd4;
			fd_valid	<= !i_redirect_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		fd_pc		<= pc;
		fd_instr	<= i_imem_data;
	end

	// ========================================================================
	// Decode
	// ========================================================================
	always_comb begin
		ctrl		= '0;
		ctrl.funct3	= fd_instr.r_fmt.funct3;
		imm			= {{20{fd_instr.i_fmt.imm[11]}}, fd_instr.i_fmt.imm};
		rs1			= fd_instr.r_fmt.rs1;
		case (fd_instr.r_fmt.opcode)
			`OPC_OP: begin
				ctrl.alu_op	= alu_sel(fd_instr.r_fmt.funct3, fd_instr.r_fmt.funct7[5]);
				ctrl.reg_we	= 1'b1;
			end
			`OPC_OP_IMM: begin
				// Only shifts take the alternate encoding from the immediate
				ctrl.alu_op		= alu_sel(fd_instr.r_fmt.funct3,
					fd_instr.r_fmt.funct3 == `F3_SR && fd_instr.r_fmt.funct7[5]);
				ctrl.src_b_imm	= 1'b1;
				ctrl.reg_we		= 1'b1;
			end
			`OPC_LUI: begin
				// x0 as operand A turns the add into a plain pass
				ctrl.src_b_imm	= 1'b1;
				ctrl.reg_we		= 1'b1;
				imm				= {fd_instr.u_fmt.imm, 12'b0};
				rs1				= 5'd0;
			end
			`OPC_AUIPC: begin
				ctrl.src_a_pc	= 1'b1;
				ctrl.src_b_imm	= 1'b1;
				ctrl.reg_we		= 1'b1;
				imm				= {fd_instr.u_fmt.imm, 12'b0};
			end
			`OPC_LOAD: begin
				ctrl.src_b_imm	= fd_instr.i_fmt.funct3 == `F3_W;
				ctrl.reg_we		= fd_instr.i_fmt.funct3 == `F3_W;
				ctrl.mem_re		= fd_instr.i_fmt.funct3 == `F3_W;
			end
			`OPC_STORE: begin
				ctrl.src_b_imm	= fd_instr.s_fmt.funct3 == `F3_W;
				ctrl.mem_we		= fd_instr.s_fmt.funct3 == `F3_W;
				imm = {{20{fd_instr.s_fmt.imm_hi[6]}}, fd_instr.s_fmt.imm_hi,
					fd_instr.s_fmt.imm_lo};
			end
			`OPC_BRANCH: begin
				ctrl.is_branch	= 1'b1;
				imm = {{20{fd_instr.b_fmt.imm12}}, fd_instr.b_fmt.imm11,
					fd_instr.b_fmt.imm10_5, fd_instr.b_fmt.imm4_1, 1'b0};
			end
			`OPC_JAL: begin
				ctrl.is_jal		= 1'b1;
				ctrl.reg_we		= 1'b1;
				ctrl.wb_link	= 1'b1;
				imm = {{12{fd_instr.j_fmt.imm20}}, fd_instr.j_fmt.imm19_12,
					fd_instr.j_fmt.imm11, fd_instr.j_fmt.imm10_1, 1'b0};
			end
			`OPC_JALR: begin
				ctrl.is_jalr	= 1'b1;
				ctrl.reg_we		= 1'b1;
				ctrl.wb_link	= 1'b1;
			end
			default: begin
				// Unknown words travel on with no side effects
			end
		endcase
	end

	rv_regfile u_regfile (
		.i_clk			(i_clk						),
		.i_rstn			(i_rstn						),
		.i_rs1			(rs1						),
		.i_rs2			(fd_instr.r_fmt.rs2			),
		.i_wb			(i_wb						),
		.o_rs1_data		(rs1_data					),
		.o_rs2_data		(rs2_data					)
	);

	// Decode/execute register
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			o_de.valid	<= 1'b0;
		end else begin
			o_de.valid	<= fd_valid && !i_redirect_valid;
		end
		o_de.pc			<= fd_pc;
		o_de.rs1_data	<= rs1_data;
		o_de.rs2_data	<= rs2_data;
		o_de.imm		<= imm;
		o_de.rs1		<= rs1;
		o_de.rs2		<= fd_instr.r_fmt.rs2;
		o_de.rd			<= fd_instr.r_fmt.rd;
		o_de.ctrl		<= ctrl;
	end

endmodule

/* design/rv_regfile.sv */
/*
 * Integer register file
 *   two combinational read ports, one write port
 *   write-first bypass, x0 hard-wired to zero
 */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_regfile (
	input  logic				i_clk,
	input  logic				i_rstn,
	input  logic [4:0]			i_rs1,
	input  logic [4:0]			i_rs2,
	input  rv_pkg::wb_fwd_t		i_wb,
	output logic [`XLEN-1:0]	o_rs1_data,
	output logic [`XLEN-1:0]	o_rs2_data
);
	logic [`XLEN-1:0]	regs [1:31];

	always_ff @(posedge i_clk) begin
		if (i_wb.we && i_wb.rd != 5'd0) begin
			regs[i_wb.rd] <= i_wb.value;
		end
	end

	// Same-cycle write wins over the stored value
	assign o_rs1_data = (i_rs1 == 5'd0) ? '0 :
		(i_wb.we && i_wb.rd == i_rs1) ? i_wb.value : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == 5'd0) ? '0 :
		(i_wb.we && i_wb.rd == i_rs2) ? i_wb.value : regs[i_rs2];

	// A write aimed at x0 leaves the stored registers untouched
	a_x0_write_ignored: assert property (@(posedge i_clk) disable iff (!i_rstn)
		(i_wb.we && i_wb.rd == 5'd0) |=> (i_rs1 != $past(i_rs1) ||
			(i_wb.we && i_wb.rd == i_rs1) || o_rs1_data == $past(o_rs1_data)));

endmodule

/* design/rv_pkg.sv */
/*
 * Shared core types
 *   instruction formats and the instruction union
 *   ALU operation enum and decode control bundle
 *   pipeline stage registers, memory request, writeback and retire report
 */
`include "rv_consts.svh"

package rv_pkg;

	typedef struct packed {
		logic [6:0]	funct7;
		logic [4:0]	rs2;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [4:0]	rd;
		logic [6:0]	opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]	imm;
		logic [4:0]		rs1;
		logic [2:0]		funct3;
		logic [4:0]		rd;
		logic [6:0]		opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]	imm_hi;
		logic [4:0]	rs2;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [4:0]	imm_lo;
		logic [6:0]	opcode;
	} s_fmt_t;

	typedef struct packed {
		logic		imm12;
		logic [5:0]	imm10_5;
		logic [4:0]	rs2;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [3:0]	imm4_1;
		logic		imm11;
		logic [6:0]	opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]	imm;
		logic [4:0]		rd;
		logic [6:0]		opcode;
	} u_fmt_t;

	typedef struct packed {
		logic		imm20;
		logic [9:0]	imm10_1;
		logic		imm11;
		logic [7:0]	imm19_12;
		logic [4:0]	rd;
		logic [6:0]	opcode;
	} j_fmt_t;

	// One fetched word, viewed in every encoding
	typedef union packed {
		r_fmt_t	r_fmt;
		i_fmt_t	i_fmt;
		s_fmt_t	s_fmt;
		b_fmt_t	b_fmt;
		u_fmt_t	u_fmt;
		j_fmt_t	j_fmt;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
	} alu_op_e;

	typedef struct packed {
		alu_op_e	alu_op;
		logic		src_a_pc;
		logic		src_b_imm;
		logic		reg_we;
		logic		mem_we;
		logic		mem_re;
		logic		is_branch;
		logic		is_jal;
		logic		is_jalr;
		logic		wb_link;
		logic [2:0]	funct3;
	} ex_ctrl_t;

	typedef struct packed {
		logic				valid;
		logic [`XLEN-1:0]	pc;
		logic [`XLEN-1:0]	rs1_data;
		logic [`XLEN-1:0]	rs2_data;
		logic [`XLEN-1:0]	imm;
		logic [4:0]			rs1;
		logic [4:0]			rs2;
		logic [4:0]			rd;
		ex_ctrl_t			ctrl;
	} de_stage_t;

	typedef struct packed {
		logic				valid;
		logic [`XLEN-1:0]	pc;
		logic [4:0]			rd;
		logic				reg_we;
		logic				is_load;
		logic [`XLEN-1:0]	value;
	} ew_stage_t;

	typedef struct packed {
		logic				re;
		logic				we;
		logic [`XLEN-1:0]	addr;
		logic [`XLEN-1:0]	wdata;
	} dmem_req_t;

	typedef struct packed {
		logic				valid;
		logic [`XLEN-1:0]	pc;
		logic [4:0]			rd;
		logic				we;
		logic [`XLEN-1:0]	value;
	} retire_t;

	typedef struct packed {
		logic				we;
		logic [4:0]			rd;
		logic [`XLEN-1:0]	value;
	} wb_fwd_t;

endpackage

/* design/rv_consts.svh */
/*
 * Core-wide constants
 *   data width and reset PC
 *   RV32I major opcodes
 *   funct3 codes for ALU, branch and word memory operations
 */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN		32
`define RESET_PC	32'h0000_0000

// Major opcodes
`define OPC_OP		7'b0110011
`define OPC_OP_IMM	7'b0010011
`define OPC_LUI		7'b0110111
`define OPC_AUIPC	7'b0010111
`define OPC_LOAD	7'b0000011
`define OPC_STORE	7'b0100011
`define OPC_BRANCH	7'b1100011
`define OPC_JAL		7'b1101111
`define OPC_JALR	7'b1100111

// ALU funct3
`define F3_ADD		3'b000
`define F3_SLL		3'b001
`define F3_SLT		3'b010
`define F3_SLTU		3'b011
`define F3_XOR		3'b100
`define F3_SR		3'b101
`define F3_OR		3'b110
`define F3_AND		3'b111

// Branch funct3
`define F3_BEQ		3'b000
`define F3_BNE		3'b001
`define F3_BLT		3'b100
`define F3_BGE		3'b101
`define F3_BLTU		3'b110
`define F3_BGEU		3'b111

// Only word accesses
`define F3_W		3'b010

`endif
